// ==== build.f ====
+incdir+test
source/mfb_split_pkg.sv
source/mfb_region_router.sv
source/mfb_output_stage.sv
source/mfb_splitter.sv
test/tb_mfb_splitter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the frame splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal \
    --top-module tb_mfb_splitter \
    -Mdir "$OBJ" \
    -f build.f
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

"./$OBJ/Vtb_mfb_splitter" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if ! grep -q "All tests passed!" "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi

echo "Simulation PASSED"
exit 0

// ==== test/mfb_split_model.svh ====
// Testbench model for the frame splitter
// LCG, frame placement over bus regions and reference functions

`ifndef MFB_SPLIT_MODEL_SVH
`define MFB_SPLIT_MODEL_SVH

localparam int NUM_FRAMES   = 300;
localparam int MAX_LEN      = 40;
localparam int REGION_ITEMS = REGION_SIZE*BLOCK_SIZE;
localparam int MAX_REGIONS  = 3*NUM_FRAMES + 2;     // One gap and two regions per frame

int unsigned gen_state = 59799;
int unsigned rdy_state;

int         f_len   [NUM_FRAMES];
int         f_sel   [NUM_FRAMES];
logic [7:0] f_meta  [NUM_FRAMES];
logic [7:0] f_bytes [NUM_FRAMES][MAX_LEN];

logic       reg_sof     [MAX_REGIONS];
logic       reg_eof     [MAX_REGIONS];
int         reg_eof_pos [MAX_REGIONS];
int         reg_sel     [MAX_REGIONS];
logic [7:0] reg_meta    [MAX_REGIONS];
int         reg_frame   [MAX_REGIONS];              // Frame covering the region, or -1
logic [7:0] reg_bytes   [MAX_REGIONS][REGION_ITEMS];
int         num_regions;

function automatic int unsigned lcg_next(inout int unsigned state);
    state = state * 32'd1103515245 + 32'd12345;
    return state >> 16;
endfunction

function automatic int expected_dest(int f);
    return f_sel[f];
endfunction

function automatic logic [7:0] expected_byte(int f, int k);
    return f_bytes[f][k];
endfunction

// Outputs that own any region of word w
function automatic out_mask_t word_receivers(int w);
    out_mask_t m;
    int        idx;
    m = '0;
    for (int r = 0; r < REGIONS; r++) begin
        idx = w*REGIONS + r;
        if (reg_frame[idx] >= 0) begin
            m[expected_dest(reg_frame[idx])] = 1'b1;
        end
    end
    return m;
endfunction

task automatic build_frames();
    int p;
    int e;
    int e_reg;
    p = 0;
    for (int r = 0; r < MAX_REGIONS; r++) begin
        reg_sof[r]     = 1'b0;
        reg_eof[r]     = 1'b0;
        reg_eof_pos[r] = 0;
        reg_frame[r]   = -1;
        reg_sel[r]     = int'(lcg_next(gen_state) % SPLITTER_OUTPUTS);  // Stale select
        reg_meta[r]    = 8'(lcg_next(gen_state));
        for (int k = 0; k < REGION_ITEMS; k++) begin
            reg_bytes[r][k] = 8'(lcg_next(gen_state));
        end
    end
    for (int f = 0; f < NUM_FRAMES; f++) begin
        if (lcg_next(gen_state) % 8 == 0) begin
            p = p + 1;                                  // Idle region
        end
        f_len[f]  = 1 + int'(lcg_next(gen_state) % MAX_LEN);
        f_sel[f]  = int'(lcg_next(gen_state) % SPLITTER_OUTPUTS);
        f_meta[f] = 8'(lcg_next(gen_state));
        for (int k = 0; k < f_len[f]; k++) begin
            f_bytes[f][k] = 8'(lcg_next(gen_state));
            reg_bytes[p + k/REGION_ITEMS][k%REGION_ITEMS] = f_bytes[f][k];
            reg_frame[p + k/REGION_ITEMS] = f;
        end
        e     = f_len[f] - 1;
        e_reg = p + e/REGION_ITEMS;
        reg_sof[p]         = 1'b1;
        reg_sel[p]         = f_sel[f];
        reg_meta[p]        = f_meta[f];
        reg_eof[e_reg]     = 1'b1;
        reg_eof_pos[e_reg] = e % REGION_ITEMS;
        p = e_reg + 1;
    end
    num_regions = ((p + REGIONS - 1) / REGIONS) * REGIONS;
endtask

`endif

// ==== test/tb_mfb_splitter.sv ====
// Testbench for the multi-region frame splitter
// Stimulus driver, ready generator, per-output collectors and checks

`timescale 1ns/1ps

module tb_mfb_splitter;
    import mfb_split_pkg::*;

    localparam int SEL_WIDTH  = $clog2(SPLITTER_OUTPUTS);
    localparam int RX_META_W  = META_WIDTH + SEL_WIDTH;
    localparam int DATA_WIDTH = REGIONS*REGION_SIZE*BLOCK_SIZE*ITEM_WIDTH;
    localparam int SOF_POS_W  = $clog2(REGION_SIZE);
    localparam int EOF_POS_W  = $clog2(REGION_SIZE*BLOCK_SIZE);
    localparam int TIMEOUT    = 2000;

    `include "mfb_split_model.svh"

    logic                                 clk;
    logic                                 rst_n;
    logic [DATA_WIDTH-1:0]                rx_data;
    logic [REGIONS*RX_META_W-1:0]         rx_meta;
    logic [REGIONS-1:0]                   rx_sof;
    logic [REGIONS-1:0]                   rx_eof;
    logic [REGIONS*SOF_POS_W-1:0]         rx_sof_pos;
    logic [REGIONS*EOF_POS_W-1:0]         rx_eof_pos;
    logic                                 rx_src_rdy;
    logic                                 rx_dst_rdy;
    logic [DATA_WIDTH-1:0]                tx_data    [SPLITTER_OUTPUTS-1:0];
    logic [REGIONS*META_WIDTH-1:0]        tx_meta    [SPLITTER_OUTPUTS-1:0];
    logic [REGIONS-1:0]                   tx_sof     [SPLITTER_OUTPUTS-1:0];
    logic [REGIONS-1:0]                   tx_eof     [SPLITTER_OUTPUTS-1:0];
    logic [REGIONS*SOF_POS_W-1:0]         tx_sof_pos [SPLITTER_OUTPUTS-1:0];
    logic [REGIONS*EOF_POS_W-1:0]         tx_eof_pos [SPLITTER_OUTPUTS-1:0];
    logic [SPLITTER_OUTPUTS-1:0]          tx_src_rdy;
    logic [SPLITTER_OUTPUTS-1:0]          tx_dst_rdy;

    int         exp_q     [SPLITTER_OUTPUTS][$];    // Frame indices per output
    logic [7:0] got_bytes [SPLITTER_OUTPUTS][$];
    logic [7:0] got_meta  [SPLITTER_OUTPUTS];
    logic       in_frame  [SPLITTER_OUTPUTS];
    int         cur_word;
    logic       phase_b;                            // Random back-pressure phase
    logic       last_xfer;
    out_mask_t  last_recv;
    logic       prev_all_rdy;
    int         errors;

    mfb_splitter #(
        .SPLITTER_OUTPUTS (SPLITTER_OUTPUTS),
        .REGIONS          (REGIONS),
        .REGION_SIZE      (REGION_SIZE),
        .BLOCK_SIZE       (BLOCK_SIZE),
        .ITEM_WIDTH       (ITEM_WIDTH),
        .META_WIDTH       (META_WIDTH)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_meta    (rx_meta),
        .rx_sof     (rx_sof),
        .rx_eof     (rx_eof),
        .rx_sof_pos (rx_sof_pos),
        .rx_eof_pos (rx_eof_pos),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx_data    (tx_data),
        .tx_meta    (tx_meta),
        .tx_sof     (tx_sof),
        .tx_eof     (tx_eof),
        .tx_sof_pos (tx_sof_pos),
        .tx_eof_pos (tx_eof_pos),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    always #4 clk = ~clk;

    task automatic abort_run(string msg);
        errors = errors + 1;
        $display("Error at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string what, int got, int exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic check_frame(int o);
        int f;
        if (exp_q[o].size() == 0) begin
            abort_run($sformatf("output %0d delivered a frame that was not expected", o));
        end
        f = exp_q[o].pop_front();
        check_value($sformatf("out %0d frame %0d length", o, f), got_bytes[o].size(), f_len[f]);
        for (int k = 0; k < f_len[f] && k < got_bytes[o].size(); k++) begin
            check_value($sformatf("out %0d frame %0d byte %0d", o, f, k),
                        got_bytes[o][k], expected_byte(f, k));
        end
        check_value($sformatf("out %0d frame %0d meta", o, f), got_meta[o], f_meta[f]);
    endtask

    // Rebuilds frames of one output from a transferred word
    task automatic collect_output(int o);
        int hi;
        for (int r = 0; r < REGIONS; r++) begin
            if (tx_sof[o][r]) begin
                check_value("tx_sof_pos", tx_sof_pos[o][r*SOF_POS_W +: SOF_POS_W], 0);
                if (in_frame[o]) begin
                    abort_run($sformatf("output %0d got a start inside an open frame", o));
                end
                in_frame[o] = 1'b1;
                got_bytes[o].delete();
                got_meta[o] = tx_meta[o][r*META_WIDTH +: META_WIDTH];
            end
            if (in_frame[o]) begin
                hi = tx_eof[o][r] ? int'(tx_eof_pos[o][r*EOF_POS_W +: EOF_POS_W])
                                  : REGION_ITEMS - 1;
                for (int k = 0; k <= hi; k++) begin
                    got_bytes[o].push_back(
                        tx_data[o][(r*REGION_ITEMS + k)*ITEM_WIDTH +: ITEM_WIDTH]);
                end
                if (tx_eof[o][r]) begin
                    check_frame(o);
                    in_frame[o] = 1'b0;
                end
            end else if (tx_eof[o][r]) begin
                abort_run($sformatf("output %0d got an end without a start", o));
            end
        end
    endtask

    task automatic drive_word(int w);
        int idx;
        cur_word   = w;
        rx_src_rdy = 1'b1;
        for (int r = 0; r < REGIONS; r++) begin
            idx = w*REGIONS + r;
            rx_sof[r] = reg_sof[idx];
            rx_eof[r] = reg_eof[idx];
            if (reg_sof[idx]) begin
                rx_sof_pos[r*SOF_POS_W +: SOF_POS_W] = '0;  // Frames start at block 0
            end else begin
                rx_sof_pos[r*SOF_POS_W +: SOF_POS_W] = SOF_POS_W'(lcg_next(gen_state));
            end
            rx_eof_pos[r*EOF_POS_W +: EOF_POS_W] = EOF_POS_W'(reg_eof_pos[idx]);
            rx_meta[r*RX_META_W +: RX_META_W] = {sel_t'(reg_sel[idx]), reg_meta[idx]};
            for (int k = 0; k < REGION_ITEMS; k++) begin
                rx_data[(r*REGION_ITEMS + k)*ITEM_WIDTH +: ITEM_WIDTH] = reg_bytes[idx][k];
            end
        end
    endtask

    function automatic logic all_done();
        for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
            if (exp_q[o].size() != 0 || in_frame[o]) begin
                return 1'b0;
            end
        end
        return tx_src_rdy == '0;
    endfunction

    // Ready patterns stay all high until the back-pressure phase
    always @(posedge clk) begin
        int unsigned r;
        #1;
        r = lcg_next(rdy_state);
        for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
            tx_dst_rdy[o] = !phase_b || ((r >> (2*o)) % 4 != 0);
        end
    end

    // Sampled mid-cycle where all levels are settled
    always @(negedge clk) begin
        out_mask_t recv;
        out_mask_t exp_valid;
        logic      exp_rdy;
        logic      xfer;
        if (rst_n) begin
            if (prev_all_rdy) begin
                exp_valid = last_xfer ? last_recv : '0;
                check_value("tx_src_rdy one cycle after accept", tx_src_rdy, exp_valid);
            end
            recv    = '0;
            xfer    = rx_src_rdy && rx_dst_rdy;
            if (rx_src_rdy) begin
                recv    = word_receivers(cur_word);
                exp_rdy = 1'b1;
                for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
                    if (recv[o] || recv == '0) begin
                        exp_rdy = exp_rdy && (!tx_src_rdy[o] || tx_dst_rdy[o]);
                    end
                end
                check_value($sformatf("rx_dst_rdy for word %0d", cur_word), rx_dst_rdy, exp_rdy);
            end
            for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
                if (tx_src_rdy[o] && tx_dst_rdy[o]) begin
                    collect_output(o);
                end
            end
            last_xfer    = xfer;
            last_recv    = recv;
            prev_all_rdy = &tx_dst_rdy;
        end
    end

    initial begin
        int waited;
        int num_words;
        clk          = 1'b0;
        rst_n        = 1'b0;
        rx_data      = '0;
        rx_meta      = '0;
        rx_sof       = '0;
        rx_eof       = '0;
        rx_sof_pos   = '0;
        rx_eof_pos   = '0;
        rx_src_rdy   = 1'b0;
        tx_dst_rdy   = '1;
        phase_b      = 1'b0;
        cur_word     = 0;
        last_xfer    = 1'b0;
        last_recv    = '0;
        prev_all_rdy = 1'b1;
        errors       = 0;
        for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
            in_frame[o] = 1'b0;
        end
        build_frames();
        rdy_state = lcg_next(gen_state);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            exp_q[expected_dest(f)].push_back(f);
        end
        num_words = num_regions / REGIONS;

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("tx_src_rdy before traffic", tx_src_rdy, 0);
        end

        for (int w = 0; w < num_words; w++) begin
            phase_b = (w >= num_words/2);
            if (phase_b && lcg_next(gen_state) % 4 == 0) begin
                @(posedge clk);
                #1 rx_src_rdy = 1'b0;               // Idle cycle on the input
            end
            @(posedge clk);
            #1;
            drive_word(w);
            waited = 0;
            @(negedge clk);
            while (!rx_dst_rdy) begin
                waited = waited + 1;
                if (waited > TIMEOUT) begin
                    abort_run($sformatf("timeout waiting for rx_dst_rdy on word %0d", w));
                end
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1 rx_src_rdy = 1'b0;

        waited = 0;
        while (!all_done()) begin
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for the expected frames to drain");
            end
            @(negedge clk);
        end

        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "simulation stopped");
        end
    end

endmodule

// ==== source/mfb_splitter.sv ====
// Frame splitter top level
// One region router and one output stage per output

`timescale 1ns/1ps

module mfb_splitter #(
    parameter int SPLITTER_OUTPUTS = mfb_split_pkg::SPLITTER_OUTPUTS,
    parameter int REGIONS          = mfb_split_pkg::REGIONS,
    parameter int REGION_SIZE      = mfb_split_pkg::REGION_SIZE,
    parameter int BLOCK_SIZE       = mfb_split_pkg::BLOCK_SIZE,
    parameter int ITEM_WIDTH       = mfb_split_pkg::ITEM_WIDTH,
    parameter int META_WIDTH       = mfb_split_pkg::META_WIDTH,
    localparam int SEL_WIDTH       = $clog2(SPLITTER_OUTPUTS),
    localparam int DATA_WIDTH      = REGIONS*REGION_SIZE*BLOCK_SIZE*ITEM_WIDTH,
    localparam int SOF_POS_WIDTH   = REGIONS*$clog2(REGION_SIZE),
    localparam int EOF_POS_WIDTH   = REGIONS*$clog2(REGION_SIZE*BLOCK_SIZE)
) (
    input  logic                                      clk,
    input  logic                                      rst_n,

    input  logic [DATA_WIDTH-1:0]                     rx_data,
    input  logic [REGIONS*(META_WIDTH+SEL_WIDTH)-1:0] rx_meta,
    input  logic [REGIONS-1:0]                        rx_sof,
    input  logic [REGIONS-1:0]                        rx_eof,
    input  logic [SOF_POS_WIDTH-1:0]                  rx_sof_pos,
    input  logic [EOF_POS_WIDTH-1:0]                  rx_eof_pos,
    input  logic                                      rx_src_rdy,
    output logic                                      rx_dst_rdy,

    output logic [DATA_WIDTH-1:0]         tx_data    [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS*META_WIDTH-1:0] tx_meta    [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]            tx_sof     [SPLITTER_OUTPUTS-1:0],
    output logic [REGIONS-1:0]            tx_eof     [SPLITTER_OUTPUTS-1:0],
    output logic [SOF_POS_WIDTH-1:0]      tx_sof_pos [SPLITTER_OUTPUTS-1:0],
    output logic [EOF_POS_WIDTH-1:0]      tx_eof_pos [SPLITTER_OUTPUTS-1:0],
    output logic [SPLITTER_OUTPUTS-1:0]   tx_src_rdy,
    input  logic [SPLITTER_OUTPUTS-1:0]   tx_dst_rdy
);
    import mfb_split_pkg::*;

    out_mask_t    can_load;
    out_mask_t    load;
    region_mask_t own_mask    [SPLITTER_OUTPUTS-1:0];
    region_mask_t start_owner [SPLITTER_OUTPUTS-1:0];

    mfb_region_router #(
        .SPLITTER_OUTPUTS (SPLITTER_OUTPUTS),
        .REGIONS          (REGIONS),
        .META_WIDTH       (META_WIDTH)
    ) router_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_meta     (rx_meta),
        .rx_sof      (rx_sof),
        .rx_eof      (rx_eof),
        .rx_src_rdy  (rx_src_rdy),
        .can_load    (can_load),
        .rx_dst_rdy  (rx_dst_rdy),
        .load        (load),
        .own_mask    (own_mask),
        .start_owner (start_owner)
    );

    for (genvar i = 0; i < SPLITTER_OUTPUTS; i++) begin : g_out
        mfb_output_stage #(
            .REGIONS     (REGIONS),
            .REGION_SIZE (REGION_SIZE),
            .BLOCK_SIZE  (BLOCK_SIZE),
            .ITEM_WIDTH  (ITEM_WIDTH),
            .META_WIDTH  (META_WIDTH)
        ) stage_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .load        (load[i]),
            .own_mask    (own_mask[i]),
            .start_owner (start_owner[i]),
            .data        (rx_data),
            .meta        (rx_meta),
            .sof         (rx_sof),
            .sof_pos     (rx_sof_pos),
            .eof         (rx_eof),
            .eof_pos     (rx_eof_pos),
            .tx_dst_rdy  (tx_dst_rdy[i]),
            .can_load    (can_load[i]),
            .tx_data     (tx_data[i]),
            .tx_meta     (tx_meta[i]),
            .tx_sof      (tx_sof[i]),
            .tx_sof_pos  (tx_sof_pos[i]),
            .tx_eof      (tx_eof[i]),
            .tx_eof_pos  (tx_eof_pos[i]),
            .tx_src_rdy  (tx_src_rdy[i])
        );
    end

endmodule

// ==== source/mfb_output_stage.sv ====
// Output stage of the frame splitter
// Flag and metadata masking, select stripping, one registered ready/valid stage

`timescale 1ns/1ps

module mfb_output_stage #(
    parameter int REGIONS         = mfb_split_pkg::REGIONS,
    parameter int REGION_SIZE     = mfb_split_pkg::REGION_SIZE,
    parameter int BLOCK_SIZE      = mfb_split_pkg::BLOCK_SIZE,
    parameter int ITEM_WIDTH      = mfb_split_pkg::ITEM_WIDTH,
    parameter int META_WIDTH      = mfb_split_pkg::META_WIDTH,
    localparam int SEL_WIDTH      = $bits(mfb_split_pkg::sel_t),
    localparam int DATA_WIDTH     = REGIONS*REGION_SIZE*BLOCK_SIZE*ITEM_WIDTH,
    localparam int SOF_POS_WIDTH  = REGIONS*$clog2(REGION_SIZE),
    localparam int EOF_POS_WIDTH  = REGIONS*$clog2(REGION_SIZE*BLOCK_SIZE)
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load,
    input  mfb_split_pkg::region_mask_t       own_mask,
    input  mfb_split_pkg::region_mask_t       start_owner,
    input  logic [DATA_WIDTH-1:0]             data,
    input  logic [REGIONS*(META_WIDTH+SEL_WIDTH)-1:0] meta,
    input  logic [REGIONS-1:0]                sof,
    input  logic [SOF_POS_WIDTH-1:0]          sof_pos,
    input  logic [REGIONS-1:0]                eof,
    input  logic [EOF_POS_WIDTH-1:0]          eof_pos,
    input  logic                              tx_dst_rdy,
    output logic                              can_load,
    output logic [DATA_WIDTH-1:0]             tx_data,
    output logic [REGIONS*META_WIDTH-1:0]     tx_meta,
    output logic [REGIONS-1:0]                tx_sof,
    output logic [SOF_POS_WIDTH-1:0]          tx_sof_pos,
    output logic [REGIONS-1:0]                tx_eof,
    output logic [EOF_POS_WIDTH-1:0]          tx_eof_pos,
    output logic                              tx_src_rdy
);
    import mfb_split_pkg::*;

    region_mask_t                  sof_keep;
    region_mask_t                  eof_keep;
    logic [REGIONS*META_WIDTH-1:0] meta_strip;
    logic                          valid_q;
    logic [DATA_WIDTH-1:0]         data_q;
    logic [REGIONS*META_WIDTH-1:0] meta_q;
    logic [REGIONS-1:0]            sof_q;
    logic [REGIONS-1:0]            eof_q;
    logic [SOF_POS_WIDTH-1:0]      sof_pos_q;
    logic [EOF_POS_WIDTH-1:0]      eof_pos_q;

    assign sof_keep = sof & start_owner;    // Starts of our frames
    assign eof_keep = eof & own_mask;       // Ends of our frames

    // Metadata only where one of our frames starts, select dropped
    always_comb begin
        for (int r = 0; r < REGIONS; r++) begin
            if (start_owner[r]) begin
                meta_strip[r*META_WIDTH +: META_WIDTH] =
                    meta[r*(META_WIDTH+SEL_WIDTH) +: META_WIDTH];
            end else begin
                meta_strip[r*META_WIDTH +: META_WIDTH] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q    <= data;
            meta_q    <= meta_strip;
            sof_q     <= sof_keep;
            eof_q     <= eof_keep;
            sof_pos_q <= sof_pos;
            eof_pos_q <= eof_pos;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (tx_dst_rdy) begin
            valid_q <= 1'b0;                // Word left, nothing new
        end
    end

    assign can_load   = !valid_q || tx_dst_rdy;

    assign tx_data    = data_q;
    assign tx_meta    = meta_q;
    assign tx_sof     = sof_q;
    assign tx_eof     = eof_q;
    assign tx_sof_pos = sof_pos_q;
    assign tx_eof_pos = eof_pos_q;
    assign tx_src_rdy = valid_q;

endmodule

// ==== source/mfb_region_router.sv ====
// Frame ownership tracking across regions and words
// Per-output region masks, load strobes and combined input ready

`timescale 1ns/1ps

module mfb_region_router #(
    parameter int SPLITTER_OUTPUTS = mfb_split_pkg::SPLITTER_OUTPUTS,
    parameter int REGIONS          = mfb_split_pkg::REGIONS,
    parameter int META_WIDTH       = mfb_split_pkg::META_WIDTH,
    localparam int SEL_WIDTH       = $clog2(SPLITTER_OUTPUTS),
    localparam int RX_META_WIDTH   = REGIONS*(META_WIDTH+SEL_WIDTH)
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [RX_META_WIDTH-1:0]    rx_meta,
    input  mfb_split_pkg::region_mask_t rx_sof,
    input  mfb_split_pkg::region_mask_t rx_eof,
    input  logic                        rx_src_rdy,
    input  mfb_split_pkg::out_mask_t    can_load,
    output logic                        rx_dst_rdy,
    output mfb_split_pkg::out_mask_t    load,
    output mfb_split_pkg::region_mask_t own_mask    [SPLITTER_OUTPUTS-1:0],
    output mfb_split_pkg::region_mask_t start_owner [SPLITTER_OUTPUTS-1:0]
);
    import mfb_split_pkg::*;

    sel_t      dst_q;                       // Destination of the open frame
    logic      open_q;                      // Frame open at the word boundary
    sel_t      region_sel  [REGIONS-1:0];
    sel_t      region_dst  [REGIONS:0];     // Carried destination at region start
    logic      region_open [REGIONS:0];     // Frame open at region start
    out_mask_t recv;                        // Outputs taking part of this word
    logic      transfer;

    // Select field sits right above the metadata of its region
    always_comb begin
        for (int r = 0; r < REGIONS; r++) begin
            region_sel[r] = rx_meta[r*(META_WIDTH+SEL_WIDTH)+META_WIDTH +: SEL_WIDTH];
        end
    end

    // Walk the regions in bus order, carrying destination and open state
    always_comb begin
        region_dst[0]  = dst_q;
        region_open[0] = open_q;
        for (int r = 0; r < REGIONS; r++) begin
            if (rx_sof[r]) begin
                // An open frame ends before the new one starts
                region_open[r+1] = !rx_eof[r] || region_open[r];
                region_dst[r+1]  = region_sel[r];
            end else if (rx_eof[r]) begin
                region_open[r+1] = 1'b0;
                region_dst[r+1]  = region_dst[r];
            end else begin
                region_open[r+1] = region_open[r];
                region_dst[r+1]  = region_dst[r];
            end
        end
    end

    // End side owner is the open frame, else the frame starting here
    always_comb begin
        for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
            for (int r = 0; r < REGIONS; r++) begin
                if (region_open[r]) begin
                    own_mask[o][r] = (region_dst[r] == sel_t'(o));
                end else begin
                    own_mask[o][r] = rx_sof[r] && (region_sel[r] == sel_t'(o));
                end
                start_owner[o][r] = rx_sof[r] && (region_sel[r] == sel_t'(o));
            end
        end
    end

    always_comb begin
        for (int o = 0; o < SPLITTER_OUTPUTS; o++) begin
            recv[o] = |(own_mask[o] | start_owner[o]);
        end
    end

    // Only receivers of the word can hold it back
    assign rx_dst_rdy = (recv == '0) ? &can_load : &(can_load | ~recv);
    assign transfer   = rx_src_rdy && rx_dst_rdy;
    assign load       = transfer ? recv : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dst_q  <= '0;
            open_q <= 1'b0;
        end else if (transfer) begin
            dst_q  <= region_dst[REGIONS];
            open_q <= region_open[REGIONS];
        end
    end

endmodule

// ==== source/mfb_split_pkg.sv ====
// Geometry defaults for the multi-region frame splitter
// Vector types for destination selects, region masks and output masks

package mfb_split_pkg;

    // Bus geometry, top level and testbench defaults
    localparam int SPLITTER_OUTPUTS = 4;
    localparam int REGIONS          = 2;
    localparam int REGION_SIZE      = 4;    // Blocks per region
    localparam int BLOCK_SIZE       = 8;    // Items per block
    localparam int ITEM_WIDTH       = 8;
    localparam int META_WIDTH       = 8;    // Without the select field

    // Destination index carried above the metadata of each region
    typedef logic [$clog2(SPLITTER_OUTPUTS)-1:0] sel_t;

    // One bit per region of a word
    typedef logic [REGIONS-1:0] region_mask_t;

    // One bit per output
    typedef logic [SPLITTER_OUTPUTS-1:0] out_mask_t;

endpackage
